//--- flist.f
hdl/bus_pkg.sv
hdl/display_pkg.sv
hdl/reg_bank.sv
hdl/digit_scanner.sv
hdl/shift_lane.sv
hdl/segm7_top.sv
tb/hc595_model.sv
tb/tb_segm7.sv

//--- hdl/bus_pkg.sv
package bus_pkg;

    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;

    localparam logic [ADDR_WIDTH-1:0] DISPLAY_ADDR = 16'h0000; // only register on the port

    // reduced write channel, strobes only
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] awaddr;
        logic                  awvalid;
        logic [DATA_WIDTH-1:0] wdata;
        logic                  wvalid;
    } wr_req_t;

endpackage

//--- hdl/digit_scanner.sv
`timescale 1ns/1ns

module digit_scanner
    import bus_pkg::*;
    import display_pkg::*;
(
    input  logic                              clk,
    input  logic                              S_AXI_ARSTN,
    input  logic [DATA_WIDTH-1:0]             display_word,
    input  logic                              done,
    output logic                              tick,
    output logic                              load,
    output lane_word_t [LANE_COUNT-1:0]       word
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        WAIT
    } state_t;

    state_t                      state;
    logic [$clog2(PRESCALE)-1:0] pre_cnt;
    hex_frame_t                  frame;
    digit_idx_t                  digit;

    // divide by PRESCALE clock enable
    always_ff @(posedge clk) begin
        if (!S_AXI_ARSTN) begin
            pre_cnt <= '0;
        end else if (pre_cnt == PRESCALE - 1) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    assign tick = (pre_cnt == '0);

    always_ff @(posedge clk) begin
        if (!S_AXI_ARSTN) begin
            state <= IDLE;
            digit <= '0;
        end else if (tick) begin
            case (state)
                IDLE: begin
                    digit <= '0;    // new frame
                    state <= LOAD;
                end
                LOAD: begin
                    state <= WAIT;
                end
                WAIT: begin
                    if (done) begin
                        if (digit == digit_idx_t'(DIGIT_COUNT - 1)) begin
                            state <= IDLE;
                        end else begin
                            digit <= digit + 1'b1;
                            state <= LOAD;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // snapshot so a write mid frame only shows up in the next frame
    always_ff @(posedge clk) begin
        if (tick && state == IDLE) begin
            frame <= display_word;
        end
    end

    assign load = (state == LOAD) && tick;

    assign word[COM_LANE] = ~(lane_word_t'(1) << digit);            // active low select
    assign word[SEG_LANE] = hex_to_glyph(frame[digit*4 +: 4]);

    done_in_wait_a: assert property (
        @(posedge clk) disable iff (!S_AXI_ARSTN)
        done |-> (state == WAIT)
    ) else $error("digit_scanner: done while no digit is shifting");

endmodule

//--- hdl/display_pkg.sv
package display_pkg;

    localparam int DIGIT_COUNT = 8;
    localparam int LANE_COUNT  = 2;
    localparam int PRESCALE    = 4;    // clk cycles per tick

    localparam int COM_LANE = 0;       // digit select chain
    localparam int SEG_LANE = 1;       // segment chain

    typedef logic [7:0] lane_word_t;
    typedef logic [4*DIGIT_COUNT-1:0] hex_frame_t;
    typedef logic [$clog2(DIGIT_COUNT)-1:0] digit_idx_t;

    typedef struct packed {
        logic ser;
        logic srclk;
        logic rclk;
    } lane_pins_t;

    // segment a at bit 6 down to g at bit 0, no decimal point
    function automatic lane_word_t hex_to_glyph(input logic [3:0] hex);
        lane_word_t glyph;
        case (hex)
            4'h0: glyph = 8'h7e;
            4'h1: glyph = 8'h30;
            4'h2: glyph = 8'h6d;
            4'h3: glyph = 8'h79;
            4'h4: glyph = 8'h33;
            4'h5: glyph = 8'h5b;
            4'h6: glyph = 8'h5f;
            4'h7: glyph = 8'h72;
            4'h8: glyph = 8'h7f;
            4'h9: glyph = 8'h7b;
            4'ha: glyph = 8'h77;
            4'hb: glyph = 8'h1f;    // lower case b
            4'hc: glyph = 8'h4e;
            4'hd: glyph = 8'h3d;    // lower case d
            4'he: glyph = 8'h4f;
            4'hf: glyph = 8'h47;
            default: glyph = 8'h00;
        endcase
        return glyph;
    endfunction

endpackage

//--- hdl/reg_bank.sv
`timescale 1ns/1ns

module reg_bank
    import bus_pkg::*;
    import display_pkg::*;
(
    input  logic                  clk,
    input  logic                  S_AXI_ARSTN,
    input  wr_req_t               req,
    output hex_frame_t            display_word,
    output logic [DATA_WIDTH-1:0] rdata
);

    logic [DATA_WIDTH-1:0] display_reg;
    logic                  wr_en;

    // both strobes in the same cycle, no handshake
    assign wr_en = req.awvalid && req.wvalid && (req.awaddr == DISPLAY_ADDR);

    always_ff @(posedge clk) begin
        if (!S_AXI_ARSTN) begin
            display_reg <= '0;
        end else if (wr_en) begin
            display_reg <= req.wdata;
        end
    end

    assign display_word = display_reg;
    assign rdata        = display_reg;    // read back the stored word

    wdata_known_a: assert property (
        @(posedge clk) disable iff (!S_AXI_ARSTN)
        wr_en |-> !$isunknown(req.wdata)
    ) else $error("reg_bank: write accepted with unknown wdata");

endmodule

//--- hdl/segm7_top.sv
`timescale 1ns/1ns

module segm7_top
    import bus_pkg::*;
    import display_pkg::*;
(
    input  logic                  clk,
    input  logic                  S_AXI_ARSTN,
    input  wr_req_t               req,
    output logic [DATA_WIDTH-1:0] rdata,
    output lane_pins_t            com_pins,
    output lane_pins_t            seg_pins
);

    hex_frame_t                  display_word;
    logic                        tick;
    logic                        load;
    lane_word_t [LANE_COUNT-1:0] word;
    lane_pins_t [LANE_COUNT-1:0] lane_pins;
    logic       [LANE_COUNT-1:0] lane_done;

    reg_bank u_reg_bank (
        .clk          (clk),
        .S_AXI_ARSTN  (S_AXI_ARSTN),
        .req          (req),
        .display_word (display_word),
        .rdata        (rdata)
    );

    digit_scanner u_digit_scanner (
        .clk          (clk),
        .S_AXI_ARSTN  (S_AXI_ARSTN),
        .display_word (display_word),
        .done         (lane_done[COM_LANE]),    // lanes run in lockstep
        .tick         (tick),
        .load         (load),
        .word         (word)
    );

    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
        shift_lane u_shift_lane (
            .clk         (clk),
            .S_AXI_ARSTN (S_AXI_ARSTN),
            .tick        (tick),
            .load        (load),
            .word        (word[i]),
            .pins        (lane_pins[i]),
            .done        (lane_done[i])
        );
    end

    assign com_pins = lane_pins[COM_LANE];
    assign seg_pins = lane_pins[SEG_LANE];

    // segment and common outputs must latch on the same tick
    lanes_in_step_a: assert property (
        @(posedge clk) disable iff (!S_AXI_ARSTN)
        (lane_done == '0) || (lane_done == '1)
    ) else $error("segm7_top: shift lanes out of step");

endmodule

//--- hdl/shift_lane.sv
`timescale 1ns/1ns

module shift_lane
    import display_pkg::*;
(
    input  logic       clk,
    input  logic       S_AXI_ARSTN,
    input  logic       tick,
    input  logic       load,
    input  lane_word_t word,
    output lane_pins_t pins,
    output logic       done
);

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT,
        LATCH
    } state_t;

    state_t     state;
    lane_word_t data;
    logic [2:0] bit_cnt;

    always_ff @(posedge clk) begin
        if (!S_AXI_ARSTN) begin
            state   <= IDLE;
            bit_cnt <= '0;
            pins    <= '0;
        end else if (tick) begin
            case (state)
                IDLE: begin
                    if (load) begin
                        pins.ser <= word[0];    // lsb first, set up before srclk rises
                        bit_cnt  <= '0;
                        state    <= SEND;
                    end
                end
                SEND: begin
                    pins.srclk <= 1'b1;
                    state      <= WAIT;
                end
                WAIT: begin
                    pins.srclk <= 1'b0;
                    if (bit_cnt == 3'd7) begin
                        pins.rclk <= 1'b1;      // all eight bits in, latch
                        state     <= LATCH;
                    end else begin
                        bit_cnt  <= bit_cnt + 3'd1;
                        pins.ser <= data[bit_cnt + 3'd1];
                        state    <= SEND;
                    end
                end
                LATCH: begin
                    pins.rclk <= 1'b0;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tick && load && state == IDLE) begin
            data <= word;
        end
    end

    // high on the tick that ends the latch pulse
    assign done = (state == LATCH) && tick;

    clk_exclusive_a: assert property (
        @(posedge clk) disable iff (!S_AXI_ARSTN)
        !(pins.srclk && pins.rclk)
    ) else $error("shift_lane: srclk and rclk high together");

    load_in_idle_a: assert property (
        @(posedge clk) disable iff (!S_AXI_ARSTN)
        load |-> (state == IDLE)
    ) else $error("shift_lane: load while a byte is still shifting");

endmodule

//--- tb/hc595_model.sv
`timescale 1ns/1ns

module hc595_model (
    input  logic       srclk,
    input  logic       ser,
    input  logic       rclk,
    output logic [7:0] q,              // q[7] is QA, q[0] is QH
    output int         shift_count     // srclk edges between the last two latch pulses
);

    logic [7:0] shift_reg    = '0;
    logic [7:0] storage_reg  = '0;
    int         total_shifts = 0;
    int         shifts_at_latch = 0;
    int         last_count   = 0;

    // ser enters at QA and moves one stage towards QH per srclk edge
    always @(posedge srclk) begin
        shift_reg    <= {ser, shift_reg[7:1]};
        total_shifts <= total_shifts + 1;
    end

    // storage register copies the shift stages on rclk
    always @(posedge rclk) begin
        storage_reg     <= shift_reg;
        last_count      <= total_shifts - shifts_at_latch;
        shifts_at_latch <= total_shifts;
    end

    assign q           = storage_reg;
    assign shift_count = last_count;

endmodule

//--- tb/tb_segm7.sv
`timescale 1ns/1ns

module tb_segm7
    import bus_pkg::*;
    import display_pkg::*;
();

    localparam int          RESET_CYCLES  = 8;
    localparam int          LATCH_TIMEOUT = 200;    // clk cycles allowed between latch pulses
    localparam int          STIM_COUNT    = 8;
    localparam logic [31:0] LFSR_SEED     = 32'h6fba288e;

    typedef enum logic [1:0] {
        WR_NORMAL,
        WR_BAD_ADDR,
        WR_NO_WVALID
    } wr_kind_t;

    typedef struct packed {
        logic [31:0] value;
        logic        use_rand;        // take the value from the LFSR instead
        wr_kind_t    kind;
        logic [2:0]  mid;             // write right after this digit latches
        logic        takes_effect;    // expected: register and display follow the write
    } stim_t;

    logic                  clk;
    logic                  S_AXI_ARSTN;
    wr_req_t               req;
    logic [DATA_WIDTH-1:0] rdata;
    lane_pins_t            com_pins;
    lane_pins_t            seg_pins;
    logic [7:0]            com_q;
    logic [7:0]            seg_q;
    int                    com_shifts;
    int                    seg_shifts;

    stim_t       stim_table [STIM_COUNT];
    logic [31:0] lfsr_state;
    logic [31:0] shown_word;    // word the display is expected to show
    int          errors;
    int          tests_run;
    int          tests_failed;

    segm7_top DUT (
        .clk         (clk),
        .S_AXI_ARSTN (S_AXI_ARSTN),
        .req         (req),
        .rdata       (rdata),
        .com_pins    (com_pins),
        .seg_pins    (seg_pins)
    );

    hc595_model com_chip (
        .srclk       (com_pins.srclk),
        .ser         (com_pins.ser),
        .rclk        (com_pins.rclk),
        .q           (com_q),
        .shift_count (com_shifts)
    );

    hc595_model seg_chip (
        .srclk       (seg_pins.srclk),
        .ser         (seg_pins.ser),
        .rclk        (seg_pins.rclk),
        .q           (seg_q),
        .shift_count (seg_shifts)
    );

    always #20 clk = ~clk;

    // a at bit 6 down to g at bit 0
    function automatic logic [7:0] glyph_of(input logic [3:0] hex);
        logic [7:0] g;
        case (hex)
            4'h0: g = 8'h7e;
            4'h1: g = 8'h30;
            4'h2: g = 8'h6d;
            4'h3: g = 8'h79;
            4'h4: g = 8'h33;
            4'h5: g = 8'h5b;
            4'h6: g = 8'h5f;
            4'h7: g = 8'h72;
            4'h8: g = 8'h7f;
            4'h9: g = 8'h7b;
            4'ha: g = 8'h77;
            4'hb: g = 8'h1f;
            4'hc: g = 8'h4e;
            4'hd: g = 8'h3d;
            4'he: g = 8'h4f;
            default: g = 8'h47;
        endcase
        return g;
    endfunction

    function automatic int zero_position(input logic [7:0] com);
        int pos;
        pos = -1;
        for (int i = 0; i < 8; i++) begin
            if (!com[i]) begin
                pos = i;
            end
        end
        return pos;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_rand_word(output logic [31:0] w);
        w = '0;
        repeat (32) begin
            lfsr_state = lfsr_step(lfsr_state);
            w          = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic string kind_name(input wr_kind_t k);
        case (k)
            WR_NORMAL:   return "normal";
            WR_BAD_ADDR: return "wrong address";
            default:     return "missing wvalid";
        endcase
    endfunction

    task automatic check_quiet_pins();
        assert (com_pins == '0 && seg_pins == '0) else begin
            $display("[FAIL] %0t ns: pins active before first load, com %b seg %b",
                     $time, com_pins, seg_pins);
            errors++;
        end
        assert (rdata == '0) else begin
            $display("[FAIL] %0t ns: rdata %h after reset, expected 0", $time, rdata);
            errors++;
        end
    endtask

    // returns on the falling edge where the common chain's rclk is first seen high
    task automatic wait_for_latch(output logic [7:0] com, output logic [7:0] seg);
        int   cycles;
        logic was_low;
        logic seen;
        cycles  = 0;
        was_low = 1'b0;
        seen    = 1'b0;
        while (!seen && cycles < LATCH_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (!com_pins.rclk) begin
                was_low = 1'b1;
            end else if (was_low) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("Timeout: no latch pulse within %0d clock cycles", LATCH_TIMEOUT);
            $display("Test failures found");
            $finish;
        end else begin
            com = com_q;
            seg = seg_q;
        end
    endtask

    task automatic check_next_digit(input int exp_digit, input logic [31:0] exp_word);
        logic [7:0] com;
        logic [7:0] seg;
        logic [7:0] exp_seg;
        wait_for_latch(com, seg);
        exp_seg = glyph_of(exp_word[exp_digit*4 +: 4]);
        assert ($countones(~com) == 1) else begin
            $display("[FAIL] %0t ns: common byte %h selects more or less than one digit",
                     $time, com);
            errors++;
        end
        assert (zero_position(com) == exp_digit) else begin
            $display("[FAIL] %0t ns: digit %0d latched, expected digit %0d",
                     $time, zero_position(com), exp_digit);
            errors++;
        end
        assert (seg == exp_seg) else begin
            $display("[FAIL] %0t ns: digit %0d segments %h, expected %h",
                     $time, exp_digit, seg, exp_seg);
            errors++;
        end
        assert (com_shifts == 8 && seg_shifts == 8) else begin
            $display("[FAIL] %0t ns: %0d and %0d shift clocks before latch, expected 8",
                     $time, com_shifts, seg_shifts);
            errors++;
        end
        assert (seg_pins.rclk) else begin
            $display("Segment chain did not latch together with the common chain at %0t ns",
                     $time);
            errors++;
        end
    endtask

    // called on a falling edge, holds the strobes for one clk
    task automatic issue_write(input logic [31:0] value, input wr_kind_t kind);
        req.awaddr  = (kind == WR_BAD_ADDR) ? DISPLAY_ADDR + 16'h0004 : DISPLAY_ADDR;
        req.awvalid = 1'b1;
        req.wdata   = value;
        req.wvalid  = (kind != WR_NO_WVALID);
        @(negedge clk);
        req = '0;
    endtask

    task automatic report_test(input int num, input string what, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: passed", num, what);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, what, errors - errors_before);
        end
    endtask

    initial begin
        stim_t       entry;
        logic [31:0] value;
        logic [31:0] next_word;
        int          errors_before;

        clk          = 1'b0;
        S_AXI_ARSTN  = 1'b0;
        req          = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_state   = LFSR_SEED;
        shown_word   = '0;

        stim_table[0] = '{32'h76543210, 1'b0, WR_NORMAL,    3'd0, 1'b1};
        stim_table[1] = '{32'hfedcba98, 1'b0, WR_NORMAL,    3'd3, 1'b1};
        stim_table[2] = '{32'h00000000, 1'b1, WR_NORMAL,    3'd5, 1'b1};
        stim_table[3] = '{32'h00000000, 1'b1, WR_BAD_ADDR,  3'd2, 1'b0};
        stim_table[4] = '{32'h00000000, 1'b1, WR_NO_WVALID, 3'd6, 1'b0};
        stim_table[5] = '{32'h00000000, 1'b1, WR_NORMAL,    3'd1, 1'b1};
        stim_table[6] = '{32'h89abcdef, 1'b0, WR_BAD_ADDR,  3'd4, 1'b0};
        stim_table[7] = '{32'h00000000, 1'b1, WR_NORMAL,    3'd6, 1'b1};

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_quiet_pins();
        end
        S_AXI_ARSTN = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_quiet_pins();    // first load is still a tick away
        end

        errors_before = errors;
        for (int d = 0; d < DIGIT_COUNT; d++) begin
            check_next_digit(d, shown_word);
        end
        report_test(0, "reset frame", errors_before);

        for (int i = 0; i < STIM_COUNT; i++) begin
            errors_before = errors;
            entry         = stim_table[i];
            if (entry.use_rand) begin
                next_rand_word(value);
            end else begin
                value = entry.value;
            end
            next_word = entry.takes_effect ? value : shown_word;
            for (int d = 0; d <= entry.mid; d++) begin
                check_next_digit(d, shown_word);
            end
            issue_write(value, entry.kind);
            assert (rdata == next_word) else begin
                $display("[FAIL] %0t ns: rdata %h, expected %h", $time, rdata, next_word);
                errors++;
            end
            for (int d = entry.mid + 1; d < DIGIT_COUNT; d++) begin
                check_next_digit(d, shown_word);    // rest of the frame keeps the old word
            end
            for (int d = 0; d < DIGIT_COUNT; d++) begin
                check_next_digit(d, next_word);
            end
            shown_word = next_word;
            report_test(i + 1, $sformatf("%s write %h after digit %0d",
                        kind_name(entry.kind), value, entry.mid), errors_before);
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
